//--- design/dmem_tile_macros.svh
// Tile data-memory widths and sizes shared by the design and testbench.

`ifndef DMEM_TILE_MACROS_SVH
`define DMEM_TILE_MACROS_SVH

// ========================================
// Data path
// ========================================

// Data word width in bits.
`define DMEM_DATA_W 32

// One mask bit per data byte.
`define DMEM_MASK_W (`DMEM_DATA_W / 8)

// ========================================
// Memory size
// ========================================

`define DMEM_WORDS 256

// Word address; byte addresses carry two more bits.
`define DMEM_ADDR_W 8

`endif

//--- design/dmem_pkg.sv
// Memory access types shared by the port adapters and the crossbar.

`default_nettype none

package dmem_pkg;

  // Crossbar request ports.
  typedef enum logic [0:0] {
    PORT_REMOTE = 1'b0,
    PORT_LOCAL  = 1'b1
  } port_e;

  // Access opcode, store matches a write enable.
  typedef enum logic [0:0] {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // Round robin pick when both ports request.
  function automatic port_e other_port(input port_e p);
    port_e q;
    q = (p == PORT_LOCAL) ? PORT_REMOTE : PORT_LOCAL;
    return q;
  endfunction

endpackage

`default_nettype wire

//--- design/trace_pkg.sv
// Trace record types shared by the access tracer and its consumers.

`default_nettype none

`include "dmem_tile_macros.svh"

package trace_pkg;

  // Record kind, port and direction.
  typedef enum logic [1:0] {
    TRACE_REMOTE_STORE = 2'd0,
    TRACE_REMOTE_LOAD  = 2'd1,
    TRACE_LOCAL_STORE  = 2'd2,
    TRACE_LOCAL_LOAD   = 2'd3
  } trace_kind_e;

  // Byte address and data word of one access.
  typedef struct packed {
    trace_kind_e                kind;
    logic [`DMEM_ADDR_W+1:0]    addr;
    logic [`DMEM_DATA_W-1:0]    data;
  } trace_rec_t;

endpackage

`default_nettype wire

//--- design/mem_req_if.sv
// Single port memory request channel with valid/yumi handshake and load return.

`default_nettype none

`include "dmem_tile_macros.svh"

interface mem_req_if;

  logic                      v;
  dmem_pkg::mem_op_e         op;
  logic [`DMEM_ADDR_W-1:0]   addr;
  logic [`DMEM_DATA_W-1:0]   data;
  logic [`DMEM_MASK_W-1:0]   mask;
  logic                      yumi;
  logic [`DMEM_DATA_W-1:0]   rdata;
  logic                      rdata_v;

  // Requesting adapter.
  modport port (output v, op, addr, data, mask, input yumi, rdata, rdata_v);

  // Arbiter and memory.
  modport xbar (input v, op, addr, data, mask, output yumi, rdata, rdata_v);

  // Passive observer.
  modport monitor (input v, op, addr, data, mask, yumi, rdata, rdata_v);

endinterface

`default_nettype wire

//--- design/remote_apb_port.sv
// APB3 slave adapter turning network accesses into crossbar requests.

`default_nettype none

`include "dmem_tile_macros.svh"

module remote_apb_port (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [`DMEM_ADDR_W+1:0]   paddr_i,
  input  logic [`DMEM_DATA_W-1:0]   pwdata_i,
  input  logic [`DMEM_MASK_W-1:0]   pstrb_i,
  output logic [`DMEM_DATA_W-1:0]   prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  mem_req_if.port                   req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_GRANT,
    ST_WAIT_DATA
  } state_e;

  state_e state_r;
  logic   access;

  assign access = psel_i & penable_i;

  // Request only while no load is in flight.
  assign req.v    = access & (state_r != ST_WAIT_DATA);
  assign req.op   = pwrite_i ? dmem_pkg::OP_STORE : dmem_pkg::OP_LOAD;
  assign req.addr = paddr_i[`DMEM_ADDR_W+1:2];
  assign req.data = pwdata_i;
  assign req.mask = pstrb_i;

  // Writes finish on grant, reads on returned data.
  assign pready_o  = (req.yumi & pwrite_i) | ((state_r == ST_WAIT_DATA) & req.rdata_v);
  assign prdata_o  = req.rdata;
  assign pslverr_o = 1'b0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
    end else begin
      case (state_r)
        ST_IDLE, ST_WAIT_GRANT: begin
          if (req.yumi) begin
            state_r <= pwrite_i ? ST_IDLE : ST_WAIT_DATA;
          end else if (access) begin
            state_r <= ST_WAIT_GRANT;
          end else begin
            state_r <= ST_IDLE;
          end
        end
        ST_WAIT_DATA: begin
          if (req.rdata_v) begin
            state_r <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/local_core_port.sv
// Core side adapter forwarding requests and holding the last load result.

`default_nettype none

`include "dmem_tile_macros.svh"

module local_core_port (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      core_v_i,
  input  logic                      core_we_i,
  input  logic [`DMEM_ADDR_W+1:0]   core_addr_i,
  input  logic [`DMEM_DATA_W-1:0]   core_data_i,
  input  logic [`DMEM_MASK_W-1:0]   core_mask_i,
  output logic                      core_yumi_o,
  output logic [`DMEM_DATA_W-1:0]   core_rdata_o,
  output logic                      core_rdata_v_o,
  mem_req_if.port                   req
);

  logic [`DMEM_DATA_W-1:0] rdata_r;

  assign req.v    = core_v_i;
  assign req.op   = core_we_i ? dmem_pkg::OP_STORE : dmem_pkg::OP_LOAD;
  // Byte offset dropped.
  assign req.addr = core_addr_i[`DMEM_ADDR_W+1:2];
  assign req.data = core_data_i;
  assign req.mask = core_mask_i;

  assign core_yumi_o    = req.yumi;
  assign core_rdata_v_o = req.rdata_v;

  // Shared read data moves with remote loads, so keep our own copy.
  assign core_rdata_o = req.rdata_v ? req.rdata : rdata_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_r <= '0;
    end else if (req.rdata_v) begin
      rdata_r <= req.rdata;
    end
  end

endmodule

`default_nettype wire

//--- design/dmem_xbar.sv
// Round robin arbiter and byte masked word memory shared by two ports.

`default_nettype none

`include "dmem_tile_macros.svh"

module dmem_xbar (
  input  logic     clk_i,
  input  logic     reset_i,
  mem_req_if.xbar  remote_req,
  mem_req_if.xbar  local_req
);

  logic [`DMEM_DATA_W-1:0] mem [`DMEM_WORDS];

  dmem_pkg::port_e           last_gnt_r;
  dmem_pkg::port_e           gnt_port;
  logic                      gnt_v;
  logic                      both_v;

  dmem_pkg::mem_op_e         sel_op;
  logic [`DMEM_ADDR_W-1:0]   sel_addr;
  logic [`DMEM_DATA_W-1:0]   sel_data;
  logic [`DMEM_MASK_W-1:0]   sel_mask;

  logic [`DMEM_DATA_W-1:0]   rdata_r;
  logic                      rd_v_r;
  dmem_pkg::port_e           rd_port_r;

  // ========================================
  // Arbitration
  // ========================================

  assign both_v = remote_req.v & local_req.v;

  always_comb begin
    if (both_v) begin
      gnt_port = dmem_pkg::other_port(last_gnt_r);
    end else if (local_req.v) begin
      gnt_port = dmem_pkg::PORT_LOCAL;
    end else begin
      gnt_port = dmem_pkg::PORT_REMOTE;
    end
  end

  assign gnt_v           = remote_req.v | local_req.v;
  assign remote_req.yumi = gnt_v & (gnt_port == dmem_pkg::PORT_REMOTE);
  assign local_req.yumi  = gnt_v & (gnt_port == dmem_pkg::PORT_LOCAL);

  // Winner's request fields.
  assign sel_op   = local_req.yumi ? local_req.op   : remote_req.op;
  assign sel_addr = local_req.yumi ? local_req.addr : remote_req.addr;
  assign sel_data = local_req.yumi ? local_req.data : remote_req.data;
  assign sel_mask = local_req.yumi ? local_req.mask : remote_req.mask;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_gnt_r <= dmem_pkg::PORT_LOCAL;
      rd_v_r     <= 1'b0;
      rd_port_r  <= dmem_pkg::PORT_REMOTE;
    end else begin
      if (gnt_v) begin
        last_gnt_r <= gnt_port;
      end
      rd_v_r    <= gnt_v & (sel_op == dmem_pkg::OP_LOAD);
      rd_port_r <= gnt_port;
    end
  end

  // ========================================
  // Memory array
  // ========================================

  always_ff @(posedge clk_i) begin
    if (gnt_v && sel_op == dmem_pkg::OP_STORE) begin
      for (int b = 0; b < `DMEM_MASK_W; b++) begin
        if (sel_mask[b]) begin
          mem[sel_addr][b*8 +: 8] <= sel_data[b*8 +: 8];
        end
      end
    end
    if (gnt_v && sel_op == dmem_pkg::OP_LOAD) begin
      rdata_r <= mem[sel_addr];
    end
  end

  assign remote_req.rdata   = rdata_r;
  assign local_req.rdata    = rdata_r;
  assign remote_req.rdata_v = rd_v_r & (rd_port_r == dmem_pkg::PORT_REMOTE);
  assign local_req.rdata_v  = rd_v_r & (rd_port_r == dmem_pkg::PORT_LOCAL);

endmodule

`default_nettype wire

//--- design/access_tracer.sv
// Access tracer emitting one record per granted access, one cycle later.

`default_nettype none

`include "dmem_tile_macros.svh"

module access_tracer (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 freeze_i,
  mem_req_if.monitor           remote_req,
  mem_req_if.monitor           local_req,
  output logic                 trace_v_o,
  output trace_pkg::trace_rec_t trace_rec_o
);

  logic                      gnt_v;
  logic                      gnt_local;
  logic                      gnt_load;
  trace_pkg::trace_kind_e    gnt_kind;

  logic                      v_r;
  logic                      load_r;
  dmem_pkg::port_e           port_r;
  trace_pkg::trace_kind_e    kind_r;
  logic [`DMEM_ADDR_W+1:0]   addr_r;
  logic [`DMEM_DATA_W-1:0]   data_r;

  // ========================================
  // Grant cycle capture
  // ========================================

  assign gnt_v     = remote_req.yumi | local_req.yumi;
  assign gnt_local = local_req.yumi;
  assign gnt_load  = gnt_local ? (local_req.op == dmem_pkg::OP_LOAD)
                               : (remote_req.op == dmem_pkg::OP_LOAD);

  always_comb begin
    if (gnt_local) begin
      gnt_kind = gnt_load ? trace_pkg::TRACE_LOCAL_LOAD : trace_pkg::TRACE_LOCAL_STORE;
    end else begin
      gnt_kind = gnt_load ? trace_pkg::TRACE_REMOTE_LOAD : trace_pkg::TRACE_REMOTE_STORE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else begin
      v_r <= gnt_v & ~freeze_i;
    end
  end

  // Payload; byte address rebuilt from the word address.
  always_ff @(posedge clk_i) begin
    if (gnt_v) begin
      load_r <= gnt_load;
      port_r <= gnt_local ? dmem_pkg::PORT_LOCAL : dmem_pkg::PORT_REMOTE;
      kind_r <= gnt_kind;
      addr_r <= {(gnt_local ? local_req.addr : remote_req.addr), 2'b00};
      if (!gnt_load) begin
        data_r <= gnt_local ? local_req.data : remote_req.data;
      end
    end
  end

  // Loads take the word returned this cycle.
  assign trace_v_o        = v_r;
  assign trace_rec_o.kind = kind_r;
  assign trace_rec_o.addr = addr_r;
  assign trace_rec_o.data = !load_r ? data_r :
                            (port_r == dmem_pkg::PORT_LOCAL) ? local_req.rdata
                                                             : remote_req.rdata;

endmodule

`default_nettype wire

//--- design/dmem_tile_top.sv
// Tile data memory top with APB remote port, core port and access trace.

`default_nettype none

`include "dmem_tile_macros.svh"

module dmem_tile_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      freeze_i,
  // Remote port, APB3.
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [`DMEM_ADDR_W+1:0]   paddr_i,
  input  logic [`DMEM_DATA_W-1:0]   pwdata_i,
  input  logic [`DMEM_MASK_W-1:0]   pstrb_i,
  output logic [`DMEM_DATA_W-1:0]   prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // Local core port.
  input  logic                      core_v_i,
  input  logic                      core_we_i,
  input  logic [`DMEM_ADDR_W+1:0]   core_addr_i,
  input  logic [`DMEM_DATA_W-1:0]   core_data_i,
  input  logic [`DMEM_MASK_W-1:0]   core_mask_i,
  output logic                      core_yumi_o,
  output logic [`DMEM_DATA_W-1:0]   core_rdata_o,
  output logic                      core_rdata_v_o,
  // Trace, sampled every cycle.
  output logic                      trace_v_o,
  output trace_pkg::trace_rec_t     trace_rec_o
);

  mem_req_if remote_if ();
  mem_req_if local_if ();

  remote_apb_port u_remote (
    .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i, .pstrb_i,
    .prdata_o, .pready_o, .pslverr_o, .req(remote_if.port)
  );

  local_core_port u_local (
    .clk_i, .reset_i, .core_v_i, .core_we_i, .core_addr_i, .core_data_i, .core_mask_i,
    .core_yumi_o, .core_rdata_o, .core_rdata_v_o, .req(local_if.port)
  );

  dmem_xbar u_xbar (
    .clk_i, .reset_i, .remote_req(remote_if.xbar), .local_req(local_if.xbar)
  );

  access_tracer u_tracer (
    .clk_i, .reset_i, .freeze_i, .remote_req(remote_if.monitor),
    .local_req(local_if.monitor), .trace_v_o, .trace_rec_o
  );

endmodule

`default_nettype wire

//--- dv/dmem_tile_sva.sv
// Tile data memory assertions on request handshakes, grants and trace timing.

`default_nettype none

`include "dmem_tile_macros.svh"

module dmem_tile_sva (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    freeze_i,
  input logic                    r_v,
  input logic                    r_yumi,
  input dmem_pkg::mem_op_e       r_op,
  input logic [`DMEM_ADDR_W-1:0] r_addr,
  input logic [`DMEM_DATA_W-1:0] r_data,
  input logic [`DMEM_MASK_W-1:0] r_mask,
  input logic                    l_v,
  input logic                    l_yumi,
  input dmem_pkg::mem_op_e       l_op,
  input logic [`DMEM_ADDR_W-1:0] l_addr,
  input logic [`DMEM_DATA_W-1:0] l_data,
  input logic [`DMEM_MASK_W-1:0] l_mask,
  input logic                    trace_v_o
);

  // Valid and fields hold until accepted.
  a_remote_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    r_v && !r_yumi |=> r_v && $stable(r_op) && $stable(r_addr) && $stable(r_data)
                       && $stable(r_mask))
    else $error("remote request dropped or changed before accept");

  a_local_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    l_v && !l_yumi |=> l_v && $stable(l_op) && $stable(l_addr) && $stable(l_data)
                       && $stable(l_mask))
    else $error("local request dropped or changed before accept");

  a_yumi_needs_v : assert property (@(posedge clk_i) disable iff (reset_i)
    (r_yumi -> r_v) && (l_yumi -> l_v))
    else $error("accept without a request");

  a_one_grant : assert property (@(posedge clk_i) disable iff (reset_i)
    !(r_yumi && l_yumi))
    else $error("both ports granted in one cycle");

  // One record the cycle after an unfrozen grant, none otherwise.
  a_trace_follows : assert property (@(posedge clk_i) disable iff (reset_i)
    (r_yumi || l_yumi) && !freeze_i |=> trace_v_o)
    else $error("missing trace record after grant");

  a_trace_only_after_grant : assert property (@(posedge clk_i) disable iff (reset_i)
    !((r_yumi || l_yumi) && !freeze_i) |=> !trace_v_o)
    else $error("trace record without an unfrozen grant");

endmodule

bind dmem_tile_top dmem_tile_sva u_sva (
  .clk_i, .reset_i, .freeze_i,
  .r_v(remote_if.v), .r_yumi(remote_if.yumi), .r_op(remote_if.op),
  .r_addr(remote_if.addr), .r_data(remote_if.data), .r_mask(remote_if.mask),
  .l_v(local_if.v), .l_yumi(local_if.yumi), .l_op(local_if.op),
  .l_addr(local_if.addr), .l_data(local_if.data), .l_mask(local_if.mask),
  .trace_v_o
);

`default_nettype wire

//--- dv/dmem_tile_tb.sv
// Tile data memory testbench replaying golden operations on both ports.

`default_nettype none

`include "dmem_tile_macros.svh"

module dmem_tile_tb;

  localparam int MAX_LINES = 64;

  logic clk_i = 1'b0;
  logic reset_i;
  logic freeze_i;
  logic psel_i, penable_i, pwrite_i;
  logic [`DMEM_ADDR_W+1:0] paddr_i;
  logic [`DMEM_DATA_W-1:0] pwdata_i;
  logic [`DMEM_MASK_W-1:0] pstrb_i;
  logic [`DMEM_DATA_W-1:0] prdata_o;
  logic pready_o, pslverr_o;
  logic core_v_i, core_we_i;
  logic [`DMEM_ADDR_W+1:0] core_addr_i;
  logic [`DMEM_DATA_W-1:0] core_data_i;
  logic [`DMEM_MASK_W-1:0] core_mask_i;
  logic core_yumi_o, core_rdata_v_o;
  logic [`DMEM_DATA_W-1:0] core_rdata_o;
  logic trace_v_o;
  trace_pkg::trace_rec_t trace_rec_o;

  logic [259:0] gold [MAX_LINES];
  logic [`DMEM_DATA_W-1:0] model [`DMEM_WORDS];
  trace_pkg::trace_rec_t trace_q [$];
  logic [`DMEM_DATA_W-1:0] held_rdata;
  int cycles;
  int cycle_limit;

  dmem_tile_top dut (.*);

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input string name, input logic [`DMEM_DATA_W-1:0] exp,
                            input logic [`DMEM_DATA_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_rec(input string name, input trace_pkg::trace_rec_t exp,
                           input trace_pkg::trace_rec_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  // APB setup then access phase; returns one unit after the final edge.
  task automatic apb_access(input string name, input logic wr, input logic [9:0] addr,
                            input logic [31:0] wd, input logic [3:0] strb,
                            input logic [31:0] exp);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wd;
    pstrb_i   = strb;
    @(posedge clk_i);
    #1 penable_i = 1'b1;
    do @(negedge clk_i); while (!pready_o);
    if (!wr) begin
      check_word({name, " remote rdata"}, exp, prdata_o);
    end
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic core_access(input string name, input bit lag, input logic we,
                             input logic [9:0] addr, input logic [31:0] wd,
                             input logic [3:0] mask, input logic [31:0] exp);
    if (lag) begin
      @(posedge clk_i);
      #1;
    end
    core_v_i    = 1'b1;
    core_we_i   = we;
    core_addr_i = addr;
    core_data_i = wd;
    core_mask_i = mask;
    do @(negedge clk_i); while (!core_yumi_o);
    @(posedge clk_i);
    #1 core_v_i = 1'b0;
    if (!we) begin
      @(negedge clk_i);
      if (!core_rdata_v_o) begin
        abort_run({name, ": local load data did not return one cycle after accept"});
      end
      check_word({name, " local rdata"}, exp, core_rdata_o);
      @(posedge clk_i);
      #1;
    end
  endtask

  // Trace collection and continuous output checks.
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (trace_v_o) begin
        trace_q.push_back(trace_rec_o);
      end
      if (pslverr_o !== 1'b0) begin
        abort_run("pslverr_o went high");
      end
      if (core_rdata_v_o) begin
        held_rdata = core_rdata_o;
      end else if (core_rdata_o !== held_rdata) begin
        abort_run("core_rdata_o changed between local loads");
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles", cycles));
    end
  end

  // ========================================
  // Golden replay
  // ========================================

  initial begin
    int n_lines;
    logic [259:0] g;
    string name;
    int n_exp;
    reset_i = 1'b1;
    freeze_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    pstrb_i = '0;
    core_v_i = 1'b0;
    core_we_i = 1'b0;
    core_addr_i = '0;
    core_data_i = '0;
    core_mask_i = '0;
    held_rdata = '0;
    cycles = 0;
    cycle_limit = 0;
    void'($urandom(35211));
    for (int i = 0; i < MAX_LINES; i++) begin
      gold[i] = '1;
    end
    $readmemh("dv/dmem_tile_golden.txt", gold);
    n_lines = 0;
    while (n_lines < MAX_LINES && gold[n_lines][255:252] != 4'hf) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      abort_run("golden file held no operations");
    end
    cycle_limit = 20 * n_lines + 20;

    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;

    for (int i = 0; i < n_lines; i++) begin
      g = gold[i];
      name = $sformatf("line %0d", i);
      // Reference model must agree with the file before the access runs.
      if (g[256] && !g[257] && model[g[245:238]] !== g[199:168]) begin
        abort_run({name, ": golden remote load data disagrees with reference model"});
      end
      if (g[258] && !g[259] && model[g[165:158]] !== g[119:88]) begin
        abort_run({name, ": golden local load data disagrees with reference model"});
      end
      trace_q.delete();
      freeze_i = g[252];
      fork
        begin
          if (g[256]) begin
            apb_access(name, g[257], g[245:236], g[235:204], g[203:200], g[199:168]);
          end
        end
        begin
          if (g[258]) begin
            core_access(name, g[256], g[259], g[165:156], g[155:124], g[123:120],
                        g[119:88]);
          end
        end
      join
      @(negedge clk_i);
      @(negedge clk_i);
      n_exp = int'(g[248]) + int'(g[249]);
      if (trace_q.size() != n_exp) begin
        abort_run($sformatf("mismatch %s trace count expected %0d actual %0d", name,
                            n_exp, trace_q.size()));
      end
      if (n_exp == 2) begin
        if (trace_q[0] === trace_pkg::trace_rec_t'(g[87:44])) begin
          check_rec({name, " local trace"}, g[43:0], trace_q[1]);
        end else begin
          check_rec({name, " local trace"}, g[43:0], trace_q[0]);
          check_rec({name, " remote trace"}, g[87:44], trace_q[1]);
        end
      end else if (g[248]) begin
        check_rec({name, " remote trace"}, g[87:44], trace_q[0]);
      end else if (g[249]) begin
        check_rec({name, " local trace"}, g[43:0], trace_q[0]);
      end
      for (int b = 0; b < `DMEM_MASK_W; b++) begin
        if (g[256] && g[257] && g[200 + b]) begin
          model[g[245:238]][b*8 +: 8] = g[204 + b*8 +: 8];
        end
        if (g[258] && g[259] && g[120 + b]) begin
          model[g[165:158]][b*8 +: 8] = g[124 + b*8 +: 8];
        end
      end
      @(posedge clk_i);
      #1;
      freeze_i = 1'b0;
      repeat ($urandom % 4) begin
        @(posedge clk_i);
        #1;
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/dmem_tile_golden.txt
// ctl frz flags _ raddr _ rwdata _ rstrb _ rexp _ laddr _ lwdata _ lmask _ lexp _ rrec _ lrec
// ctl: b0 remote, b1 remote store, b2 local, b3 local store; flags: b0/b1 remote/local record
301_010_11223344_f_00000000_000_00000000_0_00000000_01011223344_00000000000
301_010_aabbccdd_5_00000000_000_00000000_0_00000000_010aabbccdd_00000000000
101_010_00000000_0_11bb33dd_000_00000000_0_00000000_41011bb33dd_00000000000
c02_000_00000000_0_00000000_020_55667788_f_00000000_00000000000_82055667788
c02_000_00000000_0_00000000_020_12345678_2_00000000_00000000000_82012345678
402_000_00000000_0_00000000_020_00000000_0_55665688_00000000000_c2055665688
402_000_00000000_0_00000000_010_00000000_0_11bb33dd_00000000000_c1011bb33dd
101_020_00000000_0_55665688_000_00000000_0_00000000_42055665688_00000000000
310_030_deadbeef_f_00000000_000_00000000_0_00000000_00000000000_00000000000
410_000_00000000_0_00000000_030_00000000_0_deadbeef_00000000000_00000000000
101_030_00000000_0_deadbeef_000_00000000_0_00000000_430deadbeef_00000000000
c10_000_00000000_0_00000000_040_cafef00d_f_00000000_00000000000_00000000000
402_000_00000000_0_00000000_040_00000000_0_cafef00d_00000000000_c40cafef00d
f03_050_01020304_f_00000000_060_a0b0c0d0_f_00000000_05001020304_860a0b0c0d0
503_060_00000000_0_a0b0c0d0_050_00000000_0_01020304_460a0b0c0d0_c5001020304
703_070_77777777_f_00000000_020_00000000_0_55665688_07077777777_c2055665688
d10_070_00000000_0_77777777_080_88888888_f_00000000_00000000000_00000000000
402_000_00000000_0_00000000_080_00000000_0_88888888_00000000000_c8088888888
301_3fc_0badf00d_f_00000000_000_00000000_0_00000000_3fc0badf00d_00000000000
402_000_00000000_0_00000000_3fc_00000000_0_0badf00d_00000000000_ffc0badf00d
301_3fc_11000000_8_00000000_000_00000000_0_00000000_3fc11000000_00000000000
101_3fc_00000000_0_11adf00d_000_00000000_0_00000000_7fc11adf00d_00000000000
402_000_00000000_0_00000000_022_00000000_0_55665688_00000000000_c2055665688

//--- dmem_tile.f
+incdir+design
design/dmem_pkg.sv
design/trace_pkg.sv
design/mem_req_if.sv
design/remote_apb_port.sv
design/local_core_port.sv
design/dmem_xbar.sv
design/access_tracer.sv
design/dmem_tile_top.sv
dv/dmem_tile_sva.sv
dv/dmem_tile_tb.sv

//--- Makefile
# Verilator build and run for the tile data memory testbench.

VERILATOR ?= verilator
TOP       ?= dmem_tile_tb
FLIST     ?= dmem_tile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR JOBS VFLAGS"

$(SIM_BIN): $(FLIST) $(wildcard design/*.sv design/*.svh dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
